/* Bender.yml */
package:
  name: via

sources:
  - via_pkg.sv
  - via_reg_if.sv
  - via_bus_slave.sv
  - via_port_unit.sv
  - via_timer_unit.sv
  - via_irq_ctrl.sv
  - via_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_via.sv

/* all.f */
via_pkg.sv
via_reg_if.sv
via_bus_slave.sv
via_port_unit.sv
via_timer_unit.sv
via_irq_ctrl.sv
via_top.sv
tb_clkgen.sv
tb_via.sv

/* tb_clkgen.sv */
//======================================================================
// testbench clock and reset
// free-running clock, reset held high for a fixed number of cycles
//======================================================================
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// release just after an edge, like the other inputs
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		#2;
		rst_o = 1'b0;
	end

endmodule

/* tb_via.sv */
//======================================================================
// via testbench
// bus accesses against a shadow register model, port pins, CA1/CB1
// edges, both timers and the interrupt path
//======================================================================
`timescale 1ns/1ps

module tb_via import via_pkg::*; ();

	localparam int CYCLE_LIMIT = 20000; // tests need roughly 1500 cycles
	localparam logic [6:0] IER_IMPL = 7'h72; // CA1, CB1, T1, T2

	logic      clk, rst;
	logic      cs, cyc, stb, we, ca1_drv, cb1_drv;
	byte_sel_t sel;
	reg_addr_t adr;
	data_t     wdat, rdat;
	logic      ack, irq;
	port_t     pa_drv, pb_drv, pa_out, pa_oe, pb_out, pb_oe;

	// shadow model of the register state
	data_t      sh_ora, sh_orb, sh_ddra, sh_ddrb, sh_pal, sh_pbl;
	logic [7:0] sh_acr, sh_pcr, sh_t1ll, sh_t1lh, sh_t2ll;
	logic [6:0] sh_ifr, sh_ier;

	// counter value right after its load edge, and that edge's cycle
	logic [15:0] t1_load, t2_load;
	int          t1_load_cyc = 0;
	int          t2_load_cyc = 0;

	reg_addr_t   exp_addr;
	string       exp_name;
	logic        rd_busy = 1'b0;
	int          err_cnt = 0;
	int          cyc_cnt = 0;
	logic [31:0] lfsr_q  = 32'd70655;

	tb_clkgen #(.PERIOD_NS(20), .RST_CYCLES(8)) tb_clkgen_inst (.clk_o(clk), .rst_o(rst));

	via_top #(.TIMER_W(16)) via_top_inst (
		.clk_i   (clk),
		.rst_i   (rst),
		.cs_i    (cs),
		.cyc_i   (cyc),
		.stb_i   (stb),
		.we_i    (we),
		.sel_i   (sel),
		.adr_i   (adr),
		.dat_i   (wdat),
		.dat_o   (rdat),
		.ack_o   (ack),
		.pa_i    (pa_drv),
		.pb_i    (pb_drv),
		.ca1_i   (ca1_drv),
		.cb1_i   (cb1_drv),
		.pa_o    (pa_out),
		.pa_oe_o (pa_oe),
		.pb_o    (pb_out),
		.pb_oe_o (pb_oe),
		.irq_o   (irq)
	);

	//======================================================================
	// helpers
	//======================================================================
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
	endfunction

	function automatic data_t rand_bits(int n);
		data_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[DATA_W-2:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic data_t lane_write(data_t cur, data_t wd, byte_sel_t s);
		data_t m;
		m = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
		return (cur & ~m) | (wd & m);
	endfunction

	// expected read value of a register, cyc is the cycle whose state is read
	function automatic data_t expected_value(reg_addr_t a, int cyc);
		data_t       pb_mix;
		int          k1, k2;
		logic [15:0] t1_now, t2_now;
		pb_mix = (sh_ddrb & sh_orb) | (~sh_ddrb & pb_drv);
		k1     = cyc - t1_load_cyc;
		k2     = cyc - t2_load_cyc;
		t1_now = t1_load - k1[15:0]; // one-shot count, no reload
		t2_now = t2_load - k2[15:0];
		case (a)
		REG_PA, REG_ORA: return sh_acr[ACR_PA_LE] ? sh_pal : pa_drv;
		REG_PB:   return sh_acr[ACR_PB_LE] ? sh_pbl : pb_mix;
		REG_DDRA: return sh_ddra;
		REG_DDRB: return sh_ddrb;
		REG_T1CL: return data_t'(t1_now[7:0]);
		REG_T1CH: return data_t'(t1_now[15:8]);
		REG_T2CL: return data_t'(t2_now[7:0]);
		REG_T2CH: return data_t'(t2_now[15:8]);
		REG_T1LL: return data_t'(sh_t1ll);
		REG_T1LH: return data_t'(sh_t1lh);
		REG_ACR:  return data_t'(sh_acr & 8'hE3);
		REG_PCR:  return data_t'(sh_pcr & 8'h11);
		REG_IFR:  return data_t'({|(sh_ifr & sh_ier), sh_ifr});
		REG_IER:  return data_t'(sh_ier);
		default:  return '0;
		endcase
	endfunction

	task automatic check_val(string name, data_t got, data_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic step(int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic run_access(reg_addr_t a, logic wr, data_t d, byte_sel_t s);
		adr  = a;
		we   = wr;
		wdat = d;
		sel  = s;
		cs   = 1'b1;
		cyc  = 1'b1;
		stb  = 1'b1;
		step(1);
		while (!ack)
			step(1);
		cs  = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		step(2); // slave goes through hold back to idle
	endtask

	task automatic bus_write(reg_addr_t a, data_t d, byte_sel_t s);
		run_access(a, 1'b1, d, s);
		case (a)
		REG_PA, REG_ORA: sh_ora = lane_write(sh_ora, d, s);
		REG_PB:   sh_orb  = lane_write(sh_orb, d, s);
		REG_DDRA: sh_ddra = lane_write(sh_ddra, d, s);
		REG_DDRB: sh_ddrb = lane_write(sh_ddrb, d, s);
		REG_T1LL: if (s[0]) sh_t1ll = d[7:0];
		REG_T1LH: if (s[0]) sh_t1lh = d[7:0];
		REG_T1CH: begin
			sh_t1lh     = d[7:0];
			t1_load     = {d[7:0], sh_t1ll};
			t1_load_cyc = cyc_cnt - 1; // load edge, one before the current
		end
		REG_T2CL: if (s[0]) sh_t2ll = d[7:0];
		REG_T2CH: begin
			t2_load     = {d[7:0], sh_t2ll};
			t2_load_cyc = cyc_cnt - 1;
		end
		REG_ACR:  if (s[0]) sh_acr = d[7:0];
		REG_PCR:  if (s[0]) sh_pcr = d[7:0];
		REG_IFR:  if (s[0]) sh_ifr = sh_ifr & ~d[6:0];
		REG_IER:  if (s[0]) sh_ier = d[7] ? (sh_ier | d[6:0]) & IER_IMPL : sh_ier & ~d[6:0];
		default: ;
		endcase
		if (a == REG_PA) sh_ifr[IRQ_CA1] = 1'b0;
		if (a == REG_PB) sh_ifr[IRQ_CB1] = 1'b0;
		if (a == REG_T1CH) sh_ifr[IRQ_T1] = 1'b0;
		if (a == REG_T2CH) sh_ifr[IRQ_T2] = 1'b0;
	endtask

	task automatic bus_read(reg_addr_t a, string name);
		exp_addr = a;
		exp_name = name;
		rd_busy  = 1'b1;
		run_access(a, 1'b0, '0, 4'hF);
		if (a == REG_PA) sh_ifr[IRQ_CA1] = 1'b0;
		if (a == REG_PB) sh_ifr[IRQ_CB1] = 1'b0;
		if (a == REG_T1CL) sh_ifr[IRQ_T1] = 1'b0;
		if (a == REG_T2CL) sh_ifr[IRQ_T2] = 1'b0;
	endtask

	// read data is checked mid-cycle while ack_o is high, against the
	// state of the cycle in which dat_o was loaded
	always @(negedge clk) begin
		if (ack && rd_busy) begin
			check_val(exp_name, rdat, expected_value(exp_addr, cyc_cnt - 1));
			rd_busy = 1'b0;
		end
	end

	always @(posedge clk) begin
		cyc_cnt++;
		if (cyc_cnt >= CYCLE_LIMIT) begin
			$display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//======================================================================
	// stimulus
	//======================================================================
	initial begin : main
		data_t     wd;
		byte_sel_t lanes;
		reg_addr_t a;
		string     nm;
		int        toggles;
		logic      prev;
		{cs, cyc, stb, we, ca1_drv, cb1_drv} = '0;
		sel    = '0;
		adr    = '0;
		wdat   = '0;
		pa_drv = '0;
		pb_drv = '0;
		{sh_ora, sh_orb, sh_ddra, sh_ddrb, sh_pal, sh_pbl} = '0;
		{sh_acr, sh_pcr, sh_t1ll, sh_t1lh, sh_t2ll, sh_ifr, sh_ier} = '0;
		{t1_load, t2_load} = '0;
		wait (rst === 1'b0);
		step(2);
		check_val("ack_o", data_t'(ack), '0);
		check_val("irq_o", data_t'(irq), '0);
		check_val("pa_oe_o", pa_oe, '0);
		check_val("pb_oe_o", pb_oe, '0);
		bus_read(REG_IFR, "IFR after reset");
		bus_read(REG_IER, "IER after reset");

		// direction and output registers, random byte lanes
		for (int i = 0; i < 24; i++) begin
			pa_drv = rand_bits(32);
			pb_drv = rand_bits(32);
			case (rand_bits(2))
			0: begin
				a  = REG_DDRA;
				nm = "DDRA";
			end
			1: begin
				a  = REG_DDRB;
				nm = "DDRB";
			end
			2: begin
				a  = REG_ORA;
				nm = "ORA";
			end
			default: begin
				a  = REG_PB;
				nm = "PB";
			end
			endcase
			wd    = rand_bits(32);
			lanes = byte_sel_t'(rand_bits(4));
			bus_write(a, wd, lanes);
			bus_read(a, nm);
			check_val("pa_o", pa_out, sh_ora);
			check_val("pa_oe_o", pa_oe, sh_ddra);
			check_val("pb_o", pb_out, sh_orb);
			check_val("pb_oe_o", pb_oe, sh_ddrb);
		end

		// live port inputs
		pa_drv = rand_bits(32);
		bus_read(REG_PA, "PA live");
		bus_write(REG_DDRB, rand_bits(32), 4'hF);
		bus_write(REG_PB, rand_bits(32), 4'hF);
		pb_drv = rand_bits(32);
		bus_read(REG_PB, "PB mix");
		bus_read(REG_SR, "SR");

		// CA1 and CB1 rising edges with input latching
		bus_write(REG_PCR, 32'h11, 4'h1);
		bus_write(REG_ACR, 32'h03, 4'h1);
		bus_read(REG_PCR, "PCR");
		pa_drv = rand_bits(32);
		step(3);
		ca1_drv = 1'b1;
		step(6);
		sh_ifr[IRQ_CA1] = 1'b1;
		sh_pal = pa_drv;
		pa_drv = rand_bits(32);
		bus_read(REG_IFR, "IFR CA1 set");
		bus_read(REG_PA, "PA latched");
		bus_read(REG_IFR, "IFR CA1 cleared");
		pa_drv = rand_bits(32);
		step(3);
		ca1_drv = 1'b0; // wrong polarity
		step(6);
		bus_read(REG_IFR, "IFR CA1 falling");
		bus_read(REG_PA, "PA latch held");
		pb_drv = rand_bits(32);
		step(3);
		sh_pbl = (sh_ddrb & sh_orb) | (~sh_ddrb & pb_drv);
		cb1_drv = 1'b1;
		step(6);
		sh_ifr[IRQ_CB1] = 1'b1;
		pb_drv = rand_bits(32);
		bus_read(REG_IFR, "IFR CB1 set");
		bus_read(REG_PB, "PB latched");
		bus_read(REG_IFR, "IFR CB1 cleared");

		// timer 1 one-shot
		bus_write(REG_T1LL, 32'd20, 4'hF);
		bus_write(REG_T1CH, 32'd0, 4'hF);
		bus_read(REG_IFR, "IFR T1 early");
		step(40);
		sh_ifr[IRQ_T1] = 1'b1;
		bus_read(REG_IFR, "IFR T1 set");
		bus_read(REG_T1LL, "T1LL");
		bus_read(REG_T1LH, "T1LH");
		bus_read(REG_T1CL, "T1CL");
		bus_read(REG_IFR, "IFR T1 cleared");
		step(100);
		bus_read(REG_IFR, "IFR T1 one-shot");

		// timer 1 free-running, PB7 toggles
		bus_write(REG_T1LL, 32'd30, 4'hF);
		bus_write(REG_ACR, 32'hC3, 4'h1);
		bus_read(REG_ACR, "ACR");
		bus_write(REG_T1CH, 32'd0, 4'hF);
		prev = pb_out[7];
		toggles = 0;
		for (int k = 0; k < 2 * 31 + 4; k++) begin
			step(1);
			if (pb_out[7] !== prev) begin
				toggles++;
				prev = pb_out[7];
			end
		end
		check_val("pb_o[7] toggles >= 2", data_t'(toggles >= 2), 32'd1);

		// a T1CH write while PB7 is high drives it low
		while (pb_out[7] !== 1'b1)
			step(1);
		bus_write(REG_T1CH, 32'd0, 4'hF);
		check_val("pb_o[7] after T1CH", data_t'(pb_out[7]), '0);
		bus_write(REG_ACR, 32'h03, 4'h1); // back to one-shot, disarms at next zero
		step(40);
		bus_write(REG_IFR, 32'h7F, 4'h1);
		bus_read(REG_IFR, "IFR all cleared");
		check_val("pb_o", pb_out, sh_orb);

		// timer 2 one-shot
		bus_write(REG_T2CL, 32'd25, 4'hF);
		bus_write(REG_T2CH, 32'd0, 4'hF);
		bus_read(REG_IFR, "IFR T2 early");
		step(50);
		sh_ifr[IRQ_T2] = 1'b1;
		bus_read(REG_IFR, "IFR T2 set");
		bus_write(REG_T2CH, 32'hFF, 4'hF);
		bus_read(REG_IFR, "IFR T2 cleared");

		// interrupt enable and irq_o
		ca1_drv = 1'b1;
		step(6);
		sh_ifr[IRQ_CA1] = 1'b1;
		sh_pal = pa_drv;
		check_val("irq_o IER off", data_t'(irq), '0);
		bus_read(REG_IFR, "IFR IER off");
		bus_write(REG_IER, 32'h82, 4'h1);
		step(1);
		check_val("irq_o IER set", data_t'(irq), 32'd1);
		bus_read(REG_IFR, "IFR summary");
		bus_read(REG_IER, "IER");
		bus_write(REG_IER, 32'h02, 4'h1);
		step(1);
		check_val("irq_o IER clear", data_t'(irq), '0);
		bus_write(REG_IER, 32'h82, 4'h1);
		step(1);
		check_val("irq_o IER set again", data_t'(irq), 32'd1);
		bus_write(REG_IFR, 32'h02, 4'h1);
		step(1);
		check_val("irq_o IFR clear", data_t'(irq), '0);
		bus_read(REG_IFR, "IFR after clear");
		bus_read(REG_IER, "IER kept");

		step(4);
		$display("checks done, errors: %0d", err_cnt);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* via_bus_slave.sv */
//======================================================================
// via bus front end
// qualifies cyc/stb accesses, issues one register strobe and one ack
// per access, and registers the selected read data onto dat_o
//======================================================================
`timescale 1ns/1ps

module via_bus_slave import via_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  logic      cs_i,
	input  logic      cyc_i,
	input  logic      stb_i,
	input  logic      we_i,
	input  byte_sel_t sel_i,
	input  reg_addr_t adr_i,
	input  data_t     dat_i,
	output data_t     dat_o,
	output logic      ack_o,
	via_reg_if.master bus
);

	typedef enum logic [1:0] {
		IDLE,
		RD_WAIT,
		ACK,
		HOLD
	} ack_state_t;

	ack_state_t state_q;
	logic       access;
	logic       we_q;
	data_t      rd_mux;

	assign access = cs_i & cyc_i & stb_i;

	//======================================================================
	// access sequencing
	//======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
			IDLE:    if (access) state_q <= we_i ? ACK : RD_WAIT;
			RD_WAIT: state_q <= ACK;    // read data registered here
			ACK:     state_q <= HOLD;
			HOLD:    if (!stb_i) state_q <= IDLE; // master must drop stb first
			default: state_q <= IDLE;
			endcase
		end
	end

	// capture the request once, at the start of the access
	always_ff @(posedge clk_i) begin
		if (state_q == IDLE && access) begin
			we_q      <= we_i;
			bus.addr  <= adr_i;
			bus.wdata <= dat_i;
			bus.sel   <= sel_i;
		end
		if (state_q == RD_WAIT)
			dat_o <= rd_mux;
	end

	assign bus.wr_stb = (state_q == ACK) & we_q; // write ack and strobe coincide
	assign bus.rd_stb = (state_q == RD_WAIT);
	assign ack_o      = (state_q == ACK);

	//======================================================================
	// read data select
	//======================================================================
	always_comb begin
		rd_mux = '0;
		case (bus.addr)
		REG_PB, REG_PA, REG_DDRB, REG_DDRA, REG_PCR, REG_ORA:
			rd_mux = bus.rdata_port;
		REG_T1CL, REG_T1CH, REG_T1LL, REG_T1LH, REG_T2CL, REG_T2CH:
			rd_mux = bus.rdata_timer;
		REG_ACR:
			rd_mux = bus.rdata_port | bus.rdata_timer; // latch bits and timer modes
		REG_IFR, REG_IER:
			rd_mux = bus.rdata_irq;
		REG_SR:
			rd_mux = '0;
		default:
			rd_mux = '0;
		endcase
	end

endmodule

/* via_irq_ctrl.sv */
//======================================================================
// via interrupt control
// IFR flag set/clear, IER set/clear writes, registered irq_o
//======================================================================
`timescale 1ns/1ps

module via_irq_ctrl import via_pkg::*; (
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   ca1_edge_i,
	input  logic   cb1_edge_i,
	input  logic   t1_zero_i,
	input  logic   t2_zero_i,
	output logic   irq_o,
	via_reg_if.irq regs
);

	typedef logic [IRQ_ANY-1:0] flags_t;

	// sources implemented in this core
	localparam flags_t FLAG_MASK = flags_t'((1 << IRQ_CA1) | (1 << IRQ_CB1) |
		(1 << IRQ_T1) | (1 << IRQ_T2));

	flags_t ifr_q, ier_q;
	flags_t set_v, clr_v;
	flags_t active;
	logic   acc;

	assign acc    = regs.wr_stb | regs.rd_stb;
	assign active = ifr_q & ier_q;

	always_comb begin
		set_v = '0;
		set_v[IRQ_CA1] = ca1_edge_i;
		set_v[IRQ_CB1] = cb1_edge_i;
		set_v[IRQ_T1]  = t1_zero_i;
		set_v[IRQ_T2]  = t2_zero_i;

		// side-effect clears from port and timer accesses
		clr_v = '0;
		clr_v[IRQ_CA1] = acc && regs.addr == REG_PA;
		clr_v[IRQ_CB1] = acc && regs.addr == REG_PB;
		clr_v[IRQ_T1]  = (regs.rd_stb && regs.addr == REG_T1CL) ||
			(regs.wr_stb && regs.addr == REG_T1CH);
		clr_v[IRQ_T2]  = (regs.rd_stb && regs.addr == REG_T2CL) ||
			(regs.wr_stb && regs.addr == REG_T2CH);
		if (regs.wr_stb && regs.addr == REG_IFR && regs.sel[0])
			clr_v = clr_v | regs.wdata[IRQ_ANY-1:0]; // write 1 to clear
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ifr_q <= '0;
			ier_q <= '0;
			irq_o <= 1'b0;
		end else begin
			ifr_q <= (ifr_q & ~clr_v) | set_v; // new event wins over clear
			if (regs.wr_stb && regs.addr == REG_IER && regs.sel[0]) begin
				if (regs.wdata[IRQ_ANY])
					ier_q <= (ier_q | regs.wdata[IRQ_ANY-1:0]) & FLAG_MASK;
				else
					ier_q <= ier_q & ~regs.wdata[IRQ_ANY-1:0];
			end
			irq_o <= |active;
		end
	end

	always_comb begin
		regs.rdata_irq = '0;
		case (regs.addr)
		REG_IFR: regs.rdata_irq = data_t'({|active, ifr_q});
		REG_IER: regs.rdata_irq = data_t'(ier_q);
		default: ;
		endcase
	end

endmodule

/* via_pkg.sv */
//======================================================================
// via package
// register map, bus and port widths, and the bit positions of the
// ACR, PCR and IFR/IER fields used by the VIA core
//======================================================================
package via_pkg;

	localparam int DATA_W = 32;
	localparam int PORT_W = 32;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [DATA_W/8-1:0] byte_sel_t;
	typedef logic [PORT_W-1:0] port_t;

	// register index, 6522 order
	localparam reg_addr_t REG_PB   = 4'd0;
	localparam reg_addr_t REG_PA   = 4'd1;
	localparam reg_addr_t REG_DDRB = 4'd2;
	localparam reg_addr_t REG_DDRA = 4'd3;
	localparam reg_addr_t REG_T1CL = 4'd4;
	localparam reg_addr_t REG_T1CH = 4'd5;
	localparam reg_addr_t REG_T1LL = 4'd6;
	localparam reg_addr_t REG_T1LH = 4'd7;
	localparam reg_addr_t REG_T2CL = 4'd8;
	localparam reg_addr_t REG_T2CH = 4'd9;
	localparam reg_addr_t REG_SR   = 4'd10; // reserved, reads zero
	localparam reg_addr_t REG_ACR  = 4'd11;
	localparam reg_addr_t REG_PCR  = 4'd12;
	localparam reg_addr_t REG_IFR  = 4'd13;
	localparam reg_addr_t REG_IER  = 4'd14;
	localparam reg_addr_t REG_ORA  = 4'd15; // port A, no handshake side effects

	// IFR and IER share these positions
	localparam int IRQ_CA1 = 1;
	localparam int IRQ_CB1 = 4;
	localparam int IRQ_T1  = 5;
	localparam int IRQ_T2  = 6;
	localparam int IRQ_ANY = 7; // IFR summary, IER set/clear select

	localparam int ACR_PA_LE   = 0;
	localparam int ACR_PB_LE   = 1;
	localparam int ACR_T2_MODE = 5;
	localparam int ACR_T1_MODE = 6; // lsb of the 2-bit T1 mode field
	localparam int PCR_CA1_POS = 0; // 1 = rising edge
	localparam int PCR_CB1_POS = 4;

	// replace the selected byte lanes of cur with those of wd
	function automatic data_t byte_merge(data_t cur, data_t wd, byte_sel_t sel);
		data_t res;
		res = cur;
		for (int i = 0; i < DATA_W / 8; i++) begin
			if (sel[i])
				res[8*i +: 8] = wd[8*i +: 8];
		end
		return res;
	endfunction

endpackage

/* via_port_unit.sv */
//======================================================================
// via port unit
// ports A and B with direction registers and input latches, CA1/CB1
// synchronizers with polarity-qualified edge pulses
//======================================================================
`timescale 1ns/1ps

module via_port_unit import via_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_i,
	input  port_t   pa_i,
	input  port_t   pb_i,
	input  logic    ca1_i,
	input  logic    cb1_i,
	output port_t   pa_o,
	output port_t   pa_oe_o,
	output port_t   pb_o,
	output port_t   pb_oe_o,
	input  logic    pb7_ctl_i,
	input  logic    pb7_val_i,
	output logic    ca1_edge_o,
	output logic    cb1_edge_o,
	via_reg_if.port regs
);

	port_t      pao, pbo;       // output registers
	port_t      ddra, ddrb;     // 1 = output
	port_t      pai_q, pbi_q;   // pins sampled every clock
	port_t      pal, pbl;       // input latches
	port_t      pb_live;
	logic       pa_le, pb_le;
	logic       ca1_pos, cb1_pos;
	logic [2:0] ca1_sync, cb1_sync;

	//======================================================================
	// control line synchronizers
	//======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ca1_sync <= '0;
			cb1_sync <= '0;
		end else begin
			ca1_sync <= {ca1_sync[1:0], ca1_i};
			cb1_sync <= {cb1_sync[1:0], cb1_i};
		end
	end

	// compare last two synced samples
	assign ca1_edge_o = ca1_pos ? (ca1_sync[1] & ~ca1_sync[2]) : (~ca1_sync[1] & ca1_sync[2]);
	assign cb1_edge_o = cb1_pos ? (cb1_sync[1] & ~cb1_sync[2]) : (~cb1_sync[1] & cb1_sync[2]);

	//======================================================================
	// registers
	//======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pao     <= '0;
			pbo     <= '0;
			ddra    <= '0;
			ddrb    <= '0;
			pa_le   <= 1'b0;
			pb_le   <= 1'b0;
			ca1_pos <= 1'b0;
			cb1_pos <= 1'b0;
		end else if (regs.wr_stb) begin
			case (regs.addr)
			REG_PA, REG_ORA: pao <= byte_merge(pao, regs.wdata, regs.sel);
			REG_PB:   pbo  <= byte_merge(pbo, regs.wdata, regs.sel);
			REG_DDRA: ddra <= byte_merge(ddra, regs.wdata, regs.sel);
			REG_DDRB: ddrb <= byte_merge(ddrb, regs.wdata, regs.sel);
			REG_ACR: if (regs.sel[0]) begin
				pa_le <= regs.wdata[ACR_PA_LE];
				pb_le <= regs.wdata[ACR_PB_LE];
			end
			REG_PCR: if (regs.sel[0]) begin
				ca1_pos <= regs.wdata[PCR_CA1_POS];
				cb1_pos <= regs.wdata[PCR_CB1_POS];
			end
			default: ;
			endcase
		end
	end

	// output bits read back the register, input bits the pin
	assign pb_live = (ddrb & pbo) | (~ddrb & pbi_q);

	always_ff @(posedge clk_i) begin
		pai_q <= pa_i;
		pbi_q <= pb_i;
		if (ca1_edge_o)
			pal <= pai_q;
		if (cb1_edge_o)
			pbl <= pb_live;
	end

	always_comb begin
		regs.rdata_port = '0;
		case (regs.addr)
		REG_PA, REG_ORA: regs.rdata_port = pa_le ? pal : pai_q;
		REG_PB:   regs.rdata_port = pb_le ? pbl : pb_live;
		REG_DDRA: regs.rdata_port = ddra;
		REG_DDRB: regs.rdata_port = ddrb;
		REG_ACR: begin
			regs.rdata_port[ACR_PA_LE] = pa_le;
			regs.rdata_port[ACR_PB_LE] = pb_le;
		end
		REG_PCR: begin
			regs.rdata_port[PCR_CA1_POS] = ca1_pos;
			regs.rdata_port[PCR_CB1_POS] = cb1_pos;
		end
		default: ;
		endcase
	end

	//======================================================================
	// pin outputs
	//======================================================================
	assign pa_o    = pao;
	assign pa_oe_o = ddra;
	assign pb_oe_o = ddrb;

	always_comb begin
		pb_o = pbo;
		if (pb7_ctl_i)
			pb_o[7] = pb7_val_i; // timer 1 owns PB7
	end

endmodule

/* via_reg_if.sv */
//======================================================================
// via register interface
// decoded access strobes from the bus front end, and the read data
// returned by each register unit
//======================================================================
`timescale 1ns/1ps

interface via_reg_if import via_pkg::*; ();

	logic      wr_stb;      // one cycle per write access
	logic      rd_stb;      // one cycle per read access
	reg_addr_t addr;
	data_t     wdata;
	byte_sel_t sel;
	data_t     rdata_port;
	data_t     rdata_timer;
	data_t     rdata_irq;

	modport master (
		output wr_stb, rd_stb, addr, wdata, sel,
		input  rdata_port, rdata_timer, rdata_irq
	);

	// register units decode addr themselves
	modport port (
		input  wr_stb, addr, wdata, sel,
		output rdata_port
	);

	modport timer (
		input  wr_stb, addr, wdata, sel,
		output rdata_timer
	);

	modport irq (
		input  wr_stb, rd_stb, addr, wdata, sel,
		output rdata_irq
	);

endinterface

/* via_timer_unit.sv */
//======================================================================
// via timer unit
// timer 1 (one-shot or free-running, optional PB7 output) and
// timer 2 (one-shot), each with its latch
//======================================================================
`timescale 1ns/1ps

module via_timer_unit import via_pkg::*; #(
	parameter int TIMER_W = 16 // must be even
) (
	input  logic     clk_i,
	input  logic     rst_i,
	output logic     t1_zero_o,
	output logic     t2_zero_o,
	output logic     pb7_ctl_o,
	output logic     pb7_val_o,
	via_reg_if.timer regs
);

	localparam int HALF_W = TIMER_W / 2;

	typedef logic [HALF_W-1:0] half_t;
	typedef logic [TIMER_W-1:0] count_t;

	count_t     t1_cnt, t2_cnt;
	half_t      t1_lat_lo, t1_lat_hi;
	half_t      t2_lat_lo;
	half_t      wr_hi;           // high half from a CH write
	logic       t1_armed, t2_armed;
	logic       t1_ch_wr, t2_ch_wr;
	logic [1:0] t1_mode;        // bit 0 free-run, bit 1 PB7 output
	logic       t2_mode;        // stored, read back only
	logic       pb7_q;

	// byte-lane write into a half-width latch
	function automatic half_t merge_half(half_t cur, data_t wd, byte_sel_t sel);
		return half_t'(byte_merge(data_t'(cur), wd, sel));
	endfunction

	assign wr_hi     = regs.wdata[HALF_W-1:0];
	assign t1_ch_wr  = regs.wr_stb && (regs.addr == REG_T1CH);
	assign t2_ch_wr  = regs.wr_stb && (regs.addr == REG_T2CH);
	assign t1_zero_o = t1_armed && (t1_cnt == '0);
	assign t2_zero_o = t2_armed && (t2_cnt == '0);
	assign pb7_ctl_o = t1_mode[1];
	assign pb7_val_o = pb7_q;

	//======================================================================
	// counters
	//======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			t1_cnt   <= '1;
			t2_cnt   <= '1;
			t1_armed <= 1'b0;
			t2_armed <= 1'b0;
			t1_mode  <= 2'b00;
			t2_mode  <= 1'b0;
			pb7_q    <= 1'b0;
		end else begin
			if (regs.wr_stb && regs.addr == REG_ACR && regs.sel[0]) begin
				t1_mode <= regs.wdata[ACR_T1_MODE +: 2];
				t2_mode <= regs.wdata[ACR_T2_MODE];
			end

			// timer 1
			if (t1_ch_wr) begin
				t1_cnt   <= {wr_hi, t1_lat_lo};
				t1_armed <= 1'b1;
				if (t1_mode[1])
					pb7_q <= 1'b0;
			end else if (t1_zero_o) begin
				t1_cnt   <= t1_mode[0] ? {t1_lat_hi, t1_lat_lo} : t1_cnt - 1'b1;
				t1_armed <= t1_mode[0]; // one-shot disarms
				if (t1_mode == 2'd2)
					pb7_q <= 1'b1;
				else if (t1_mode == 2'd3)
					pb7_q <= ~pb7_q;
			end else begin
				t1_cnt <= t1_cnt - 1'b1;
			end

			// timer 2, one-shot only
			if (t2_ch_wr) begin
				t2_cnt   <= {wr_hi, t2_lat_lo};
				t2_armed <= 1'b1;
			end else begin
				t2_cnt <= t2_cnt - 1'b1;
				if (t2_zero_o)
					t2_armed <= 1'b0;
			end
		end
	end

	// latches
	always_ff @(posedge clk_i) begin
		if (regs.wr_stb) begin
			case (regs.addr)
			REG_T1CL, REG_T1LL: t1_lat_lo <= merge_half(t1_lat_lo, regs.wdata, regs.sel);
			REG_T1LH: t1_lat_hi <= merge_half(t1_lat_hi, regs.wdata, regs.sel);
			REG_T1CH: t1_lat_hi <= wr_hi; // keeps free-run reload in step
			REG_T2CL: t2_lat_lo <= merge_half(t2_lat_lo, regs.wdata, regs.sel);
			default: ;
			endcase
		end
	end

	//======================================================================
	// read data
	//======================================================================
	always_comb begin
		regs.rdata_timer = '0;
		case (regs.addr)
		REG_T1CL: regs.rdata_timer = data_t'(t1_cnt[HALF_W-1:0]);
		REG_T1CH: regs.rdata_timer = data_t'(t1_cnt[TIMER_W-1:HALF_W]);
		REG_T1LL: regs.rdata_timer = data_t'(t1_lat_lo);
		REG_T1LH: regs.rdata_timer = data_t'(t1_lat_hi);
		REG_T2CL: regs.rdata_timer = data_t'(t2_cnt[HALF_W-1:0]);
		REG_T2CH: regs.rdata_timer = data_t'(t2_cnt[TIMER_W-1:HALF_W]);
		REG_ACR: begin
			regs.rdata_timer[ACR_T1_MODE +: 2] = t1_mode;
			regs.rdata_timer[ACR_T2_MODE]      = t2_mode;
		end
		default: ;
		endcase
	end

endmodule

/* via_top.sv */
//======================================================================
// via top level
// bus front end plus port, timer and interrupt units sharing one
// register interface
//======================================================================
`timescale 1ns/1ps

module via_top import via_pkg::*; #(
	parameter int TIMER_W = 16 // counter width, even
) (
	input  logic      clk_i,
	input  logic      rst_i,
	input  logic      cs_i,
	input  logic      cyc_i,
	input  logic      stb_i,
	input  logic      we_i,
	input  byte_sel_t sel_i,
	input  reg_addr_t adr_i,
	input  data_t     dat_i,
	output data_t     dat_o,
	output logic      ack_o,
	input  port_t     pa_i,
	input  port_t     pb_i,
	input  logic      ca1_i,
	input  logic      cb1_i,
	output port_t     pa_o,
	output port_t     pa_oe_o,
	output port_t     pb_o,
	output port_t     pb_oe_o,
	output logic      irq_o
);

	logic ca1_edge, cb1_edge;   // port unit to irq
	logic t1_zero, t2_zero;     // timer unit to irq
	logic pb7_ctl, pb7_val;     // timer unit to port unit

	via_reg_if regs ();

	via_bus_slave via_bus_slave_inst (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.cs_i  (cs_i),
		.cyc_i (cyc_i),
		.stb_i (stb_i),
		.we_i  (we_i),
		.sel_i (sel_i),
		.adr_i (adr_i),
		.dat_i (dat_i),
		.dat_o (dat_o),
		.ack_o (ack_o),
		.bus   (regs.master)
	);

	via_port_unit via_port_unit_inst (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.pa_i       (pa_i),
		.pb_i       (pb_i),
		.ca1_i      (ca1_i),
		.cb1_i      (cb1_i),
		.pa_o       (pa_o),
		.pa_oe_o    (pa_oe_o),
		.pb_o       (pb_o),
		.pb_oe_o    (pb_oe_o),
		.pb7_ctl_i  (pb7_ctl),
		.pb7_val_i  (pb7_val),
		.ca1_edge_o (ca1_edge),
		.cb1_edge_o (cb1_edge),
		.regs       (regs.port)
	);

	via_timer_unit #(
		.TIMER_W (TIMER_W)
	) via_timer_unit_inst (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.t1_zero_o (t1_zero),
		.t2_zero_o (t2_zero),
		.pb7_ctl_o (pb7_ctl),
		.pb7_val_o (pb7_val),
		.regs      (regs.timer)
	);

	via_irq_ctrl via_irq_ctrl_inst (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.ca1_edge_i (ca1_edge),
		.cb1_edge_i (cb1_edge),
		.t1_zero_i  (t1_zero),
		.t2_zero_i  (t2_zero),
		.irq_o      (irq_o),
		.regs       (regs.irq)
	);

endmodule
